/* hdl/dcache_cfg.svh */
// ****************************************
// Cache geometry fixed at compile time
// Address fields must sum to DCACHE_ADDR_WIDTH
// Only 2 ways are supported by the victim logic
// ****************************************

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Data word and byte enables
`define DCACHE_WORD_WIDTH     32
`define DCACHE_BYTEEN_WIDTH   4

// Word address split as tag | set | word select
`define DCACHE_ADDR_WIDTH     16
`define DCACHE_WORD_SEL_BITS  2
`define DCACHE_SET_BITS       4
`define DCACHE_TAG_BITS       10

`define DCACHE_NUM_WAYS       2
`define DCACHE_REQ_TAG_WIDTH  4

// Derived counts
`define DCACHE_NUM_SETS       (1 << `DCACHE_SET_BITS)
`define DCACHE_LINE_WORDS     (1 << `DCACHE_WORD_SEL_BITS)

`endif

/* hdl/dcache_pkg.sv */
// ****************************************
// Shared cache types
// Addresses are word addresses, not bytes
// ****************************************

`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_WIDTH-1:0]    word_t;
    typedef logic [`DCACHE_BYTEEN_WIDTH-1:0]  byteen_t;
    typedef logic [`DCACHE_REQ_TAG_WIDTH-1:0] req_tag_t;

    // Word 0 sits in the low bits of the line
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;

    // Address fields
    typedef logic [`DCACHE_TAG_BITS-1:0]      tag_t;
    typedef logic [`DCACHE_SET_BITS-1:0]      set_t;
    typedef logic [`DCACHE_WORD_SEL_BITS-1:0] wsel_t;

    typedef struct packed {
        tag_t  tag;
        set_t  set;
        wsel_t wsel;
    } addr_fields_t;

    // Flat view for memory, field view for the lookup
    typedef union packed {
        logic [`DCACHE_ADDR_WIDTH-1:0] word_addr;
        addr_fields_t                  fields;
    } addr_u;

    // One bit is enough for two ways
    typedef logic way_t;

endpackage

/* hdl/dcache_req_stage.sv */
// ****************************************
// One-entry request stage
// Requester must hold payload until ready
// ****************************************

module dcache_req_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid_i,
    input  logic                req_rw_i,
    input  dcache_pkg::addr_u   req_addr_i,
    input  dcache_pkg::byteen_t req_byteen_i,
    input  dcache_pkg::word_t   req_data_i,
    input  dcache_pkg::req_tag_t req_tag_i,
    input  logic                out_ready_i,
    output logic                req_ready_o,
    output logic                out_valid_o,
    output logic                out_rw_o,
    output dcache_pkg::addr_u   out_addr_o,
    output dcache_pkg::byteen_t out_byteen_o,
    output dcache_pkg::word_t   out_data_o,
    output dcache_pkg::req_tag_t out_tag_o
);
    import dcache_pkg::*;

    logic valid_q;

    // Free when empty or when the tag stage takes the entry this cycle
    assign req_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    // Payload loads only on a transfer
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            out_rw_o     <= req_rw_i;
            out_addr_o   <= req_addr_i;
            out_byteen_o <= req_byteen_i;
            out_data_o   <= req_data_i;
            out_tag_o    <= req_tag_i;
        end
    end

    assign out_valid_o = valid_q;

endmodule

/* hdl/dcache_tag_stage.sv */
// ****************************************
// Tag lookup stage with cyclic victim pointer
// Lookup is combinational on the held entry,
// so a refill during a stall is seen here
// ****************************************

`include "dcache_cfg.svh"

module dcache_tag_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid_i,
    input  logic                 in_rw_i,
    input  dcache_pkg::addr_u    in_addr_i,
    input  dcache_pkg::byteen_t  in_byteen_i,
    input  dcache_pkg::word_t    in_data_i,
    input  dcache_pkg::req_tag_t in_tag_i,
    input  logic                 out_ready_i,
    input  logic                 fill_valid_i,
    input  dcache_pkg::set_t     fill_set_i,
    input  dcache_pkg::way_t     fill_way_i,
    input  dcache_pkg::tag_t     fill_tag_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output logic                 out_rw_o,
    output dcache_pkg::addr_u    out_addr_o,
    output dcache_pkg::byteen_t  out_byteen_o,
    output dcache_pkg::word_t    out_data_o,
    output dcache_pkg::req_tag_t out_tag_o,
    output logic                 out_hit_o,
    output dcache_pkg::way_t     out_hit_way_o,
    output dcache_pkg::way_t     out_victim_way_o
);
    import dcache_pkg::*;

    logic valid_q;

    tag_t                       tag_arr    [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
    logic [`DCACHE_NUM_WAYS-1:0] valid_arr [`DCACHE_NUM_SETS];
    way_t                       victim_ptr [`DCACHE_NUM_SETS];

    logic [`DCACHE_NUM_WAYS-1:0] way_hit;
    set_t                        lookup_set;

    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            out_rw_o     <= in_rw_i;
            out_addr_o   <= in_addr_i;
            out_byteen_o <= in_byteen_i;
            out_data_o   <= in_data_i;
            out_tag_o    <= in_tag_i;
        end
    end

    // Valid bits and victim pointers
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
                valid_arr[s]  <= '0;
                victim_ptr[s] <= '0;
            end
        end else if (fill_valid_i) begin
            valid_arr[fill_set_i][fill_way_i] <= 1'b1;
            victim_ptr[fill_set_i]            <= victim_ptr[fill_set_i] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid_i) begin
            tag_arr[fill_set_i][fill_way_i] <= fill_tag_i;
        end
    end

    // Compare both ways of the held entry's set
    assign lookup_set = out_addr_o.fields.set;

    always_comb begin
        out_hit_way_o = '0;
        for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
            way_hit[w] = valid_arr[lookup_set][w]
                      && (tag_arr[lookup_set][w] == out_addr_o.fields.tag);
            if (way_hit[w]) begin
                out_hit_way_o = way_t'(w);
            end
        end
    end

    assign out_hit_o        = |way_hit;
    assign out_victim_way_o = victim_ptr[lookup_set];
    assign out_valid_o      = valid_q;

endmodule

/* hdl/dcache_data_stage.sv */
// ****************************************
// Write-through data stage without write-allocate
// Read misses block the stage until refilled
// Writes never answer the core
// ****************************************

`include "dcache_cfg.svh"

module dcache_data_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid_i,
    input  logic                 in_rw_i,
    input  dcache_pkg::addr_u    in_addr_i,
    input  dcache_pkg::byteen_t  in_byteen_i,
    input  dcache_pkg::word_t    in_data_i,
    input  dcache_pkg::req_tag_t in_tag_i,
    input  logic                 in_hit_i,
    input  dcache_pkg::way_t     in_hit_way_i,
    input  dcache_pkg::way_t     in_victim_way_i,
    input  logic                 core_rsp_ready_i,
    input  logic                 mem_req_ready_i,
    input  logic                 mem_rsp_valid_i,
    input  dcache_pkg::line_t    mem_rsp_data_i,
    output logic                 in_ready_o,
    output logic                 core_rsp_valid_o,
    output dcache_pkg::word_t    core_rsp_data_o,
    output dcache_pkg::req_tag_t core_rsp_tag_o,
    output logic                 mem_req_valid_o,
    output logic                 mem_req_rw_o,
    output dcache_pkg::addr_u    mem_req_addr_o,
    output dcache_pkg::word_t    mem_req_data_o,
    output dcache_pkg::byteen_t  mem_req_byteen_o,
    output logic                 mem_rsp_ready_o,
    output logic                 fill_valid_o,
    output dcache_pkg::set_t     fill_set_o,
    output dcache_pkg::way_t     fill_way_o,
    output dcache_pkg::tag_t     fill_tag_o
);
    import dcache_pkg::*;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_MEM_REQ = 2'd1;
    localparam logic [1:0] ST_REFILL  = 2'd2;
    localparam logic [1:0] ST_RESPOND = 2'd3;

    logic [1:0] state;
    logic [1:0] state_n;
    logic       accept;
    logic       refill_done;

    // Held entry
    logic     rw_q;
    addr_u    addr_q;
    byteen_t  byteen_q;
    word_t    data_q;
    req_tag_t tag_q;
    way_t     victim_q;
    word_t    rsp_data_q;

    line_t data_arr [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];

    // Ready when empty or when the current entry ends this cycle
    assign in_ready_o = (state == ST_IDLE)
                     || (state == ST_RESPOND && core_rsp_ready_i)
                     || (state == ST_MEM_REQ && rw_q && mem_req_ready_i);

    assign accept      = in_valid_i && in_ready_o;
    assign refill_done = (state == ST_REFILL) && mem_rsp_valid_i;

    always_comb begin
        state_n = state;
        case (state)
            ST_MEM_REQ: begin
                if (mem_req_ready_i) begin
                    state_n = rw_q ? ST_IDLE : ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_rsp_valid_i) begin
                    state_n = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (core_rsp_ready_i) begin
                    state_n = ST_IDLE;
                end
            end
            default: state_n = ST_IDLE;
        endcase
        // A new entry overrides the return to idle
        if (accept) begin
            state_n = (in_rw_i || !in_hit_i) ? ST_MEM_REQ : ST_RESPOND;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rw_q     <= in_rw_i;
            addr_q   <= in_addr_i;
            byteen_q <= in_byteen_i;
            data_q   <= in_data_i;
            tag_q    <= in_tag_i;
            victim_q <= in_victim_way_i;
        end
    end

    // Read hit data comes from the array, miss data from the refill line
    always_ff @(posedge clk) begin
        if (accept && !in_rw_i && in_hit_i) begin
            rsp_data_q <= data_arr[in_addr_i.fields.set][in_hit_way_i][in_addr_i.fields.wsel];
        end else if (refill_done) begin
            rsp_data_q <= mem_rsp_data_i[addr_q.fields.wsel];
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            data_arr[addr_q.fields.set][victim_q] <= mem_rsp_data_i;
        end
        if (accept && in_rw_i && in_hit_i) begin
            for (int b = 0; b < `DCACHE_BYTEEN_WIDTH; b++) begin
                if (in_byteen_i[b]) begin
                    data_arr[in_addr_i.fields.set][in_hit_way_i][in_addr_i.fields.wsel][8*b +: 8]
                        <= in_data_i[8*b +: 8];
                end
            end
        end
    end

    // Line reads go out line-aligned
    always_comb begin
        mem_req_addr_o = addr_q;
        if (!rw_q) begin
            mem_req_addr_o.fields.wsel = '0;
        end
    end

    assign mem_req_valid_o  = (state == ST_MEM_REQ);
    assign mem_req_rw_o     = rw_q;
    assign mem_req_data_o   = data_q;
    assign mem_req_byteen_o = byteen_q;
    assign mem_rsp_ready_o  = (state == ST_REFILL);

    assign core_rsp_valid_o = (state == ST_RESPOND);
    assign core_rsp_data_o  = rsp_data_q;
    assign core_rsp_tag_o   = tag_q;

    // Refill update back to the tag stage
    assign fill_valid_o = refill_done;
    assign fill_set_o   = addr_q.fields.set;
    assign fill_way_o   = victim_q;
    assign fill_tag_o   = addr_q.fields.tag;

endmodule

/* hdl/dcache_top.sv */
// ****************************************
// Single-port 2-way write-through data cache
// Up to three requests in flight
// Memory returns exactly one line per read
// ****************************************

module dcache_top (
    input  logic                 clk,
    input  logic                 reset,
    // Core request
    input  logic                 core_req_valid_i,
    output logic                 core_req_ready_o,
    input  logic                 core_req_rw_i,
    input  dcache_pkg::addr_u    core_req_addr_i,
    input  dcache_pkg::byteen_t  core_req_byteen_i,
    input  dcache_pkg::word_t    core_req_data_i,
    input  dcache_pkg::req_tag_t core_req_tag_i,
    // Core response for reads only
    output logic                 core_rsp_valid_o,
    input  logic                 core_rsp_ready_i,
    output dcache_pkg::word_t    core_rsp_data_o,
    output dcache_pkg::req_tag_t core_rsp_tag_o,
    // Memory request
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output logic                 mem_req_rw_o,
    output dcache_pkg::addr_u    mem_req_addr_o,
    output dcache_pkg::word_t    mem_req_data_o,
    output dcache_pkg::byteen_t  mem_req_byteen_o,
    // Memory response
    input  logic                 mem_rsp_valid_i,
    input  dcache_pkg::line_t    mem_rsp_data_i,
    output logic                 mem_rsp_ready_o
);
    import dcache_pkg::*;

    // Request stage to tag stage
    logic     rq_valid;
    logic     rq_ready;
    logic     rq_rw;
    addr_u    rq_addr;
    byteen_t  rq_byteen;
    word_t    rq_data;
    req_tag_t rq_tag;

    // Tag stage to data stage
    logic     tg_valid;
    logic     tg_ready;
    logic     tg_rw;
    addr_u    tg_addr;
    byteen_t  tg_byteen;
    word_t    tg_data;
    req_tag_t tg_tag;
    logic     tg_hit;
    way_t     tg_hit_way;
    way_t     tg_victim_way;

    // Refill update
    logic fill_valid;
    set_t fill_set;
    way_t fill_way;
    tag_t fill_tag;

    dcache_req_stage req_stage (
        .clk          (clk),
        .reset        (reset),
        .req_valid_i  (core_req_valid_i),
        .req_rw_i     (core_req_rw_i),
        .req_addr_i   (core_req_addr_i),
        .req_byteen_i (core_req_byteen_i),
        .req_data_i   (core_req_data_i),
        .req_tag_i    (core_req_tag_i),
        .out_ready_i  (rq_ready),
        .req_ready_o  (core_req_ready_o),
        .out_valid_o  (rq_valid),
        .out_rw_o     (rq_rw),
        .out_addr_o   (rq_addr),
        .out_byteen_o (rq_byteen),
        .out_data_o   (rq_data),
        .out_tag_o    (rq_tag)
    );

    dcache_tag_stage tag_stage (
        .clk              (clk),
        .reset            (reset),
        .in_valid_i       (rq_valid),
        .in_rw_i          (rq_rw),
        .in_addr_i        (rq_addr),
        .in_byteen_i      (rq_byteen),
        .in_data_i        (rq_data),
        .in_tag_i         (rq_tag),
        .out_ready_i      (tg_ready),
        .fill_valid_i     (fill_valid),
        .fill_set_i       (fill_set),
        .fill_way_i       (fill_way),
        .fill_tag_i       (fill_tag),
        .in_ready_o       (rq_ready),
        .out_valid_o      (tg_valid),
        .out_rw_o         (tg_rw),
        .out_addr_o       (tg_addr),
        .out_byteen_o     (tg_byteen),
        .out_data_o       (tg_data),
        .out_tag_o        (tg_tag),
        .out_hit_o        (tg_hit),
        .out_hit_way_o    (tg_hit_way),
        .out_victim_way_o (tg_victim_way)
    );

    dcache_data_stage data_stage (
        .clk              (clk),
        .reset            (reset),
        .in_valid_i       (tg_valid),
        .in_rw_i          (tg_rw),
        .in_addr_i        (tg_addr),
        .in_byteen_i      (tg_byteen),
        .in_data_i        (tg_data),
        .in_tag_i         (tg_tag),
        .in_hit_i         (tg_hit),
        .in_hit_way_i     (tg_hit_way),
        .in_victim_way_i  (tg_victim_way),
        .core_rsp_ready_i (core_rsp_ready_i),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_data_i   (mem_rsp_data_i),
        .in_ready_o       (tg_ready),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_data_o  (core_rsp_data_o),
        .core_rsp_tag_o   (core_rsp_tag_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_rw_o     (mem_req_rw_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_data_o   (mem_req_data_o),
        .mem_req_byteen_o (mem_req_byteen_o),
        .mem_rsp_ready_o  (mem_rsp_ready_o),
        .fill_valid_o     (fill_valid),
        .fill_set_o       (fill_set),
        .fill_way_o       (fill_way),
        .fill_tag_o       (fill_tag)
    );

endmodule

/* verification/dcache_asserts.sv */
// ****************************************
// Handshake and reset checks bound into
// every dcache_top instance
// ****************************************

module dcache_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 rsp_valid_i,
    input logic                 rsp_ready_i,
    input dcache_pkg::word_t    rsp_data_i,
    input dcache_pkg::req_tag_t rsp_tag_i,
    input logic                 mem_valid_i,
    input logic                 mem_ready_i,
    input logic                 mem_rw_i,
    input dcache_pkg::addr_u    mem_addr_i,
    input dcache_pkg::word_t    mem_data_i,
    input dcache_pkg::byteen_t  mem_byteen_i
);

    // Response held until the core takes it
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid_i && !rsp_ready_i |=>
            rsp_valid_i && $stable(rsp_data_i) && $stable(rsp_tag_i))
        else $error("Core response changed while stalled");

    // Memory request held until memory takes it
    assert property (@(posedge clk) disable iff (reset)
        mem_valid_i && !mem_ready_i |=>
            mem_valid_i && $stable(mem_rw_i) && $stable(mem_addr_i)
            && $stable(mem_data_i) && $stable(mem_byteen_i))
        else $error("Memory request changed while stalled");

    // Idle outputs once a reset edge has been seen
    assert property (@(posedge clk) reset |=> !rsp_valid_i && !mem_valid_i)
        else $error("Valid output high during reset");

endmodule

bind dcache_top dcache_asserts asserts (
    .clk          (clk),
    .reset        (reset),
    .rsp_valid_i  (core_rsp_valid_o),
    .rsp_ready_i  (core_rsp_ready_i),
    .rsp_data_i   (core_rsp_data_o),
    .rsp_tag_i    (core_rsp_tag_o),
    .mem_valid_i  (mem_req_valid_o),
    .mem_ready_i  (mem_req_ready_i),
    .mem_rw_i     (mem_req_rw_o),
    .mem_addr_i   (mem_req_addr_o),
    .mem_data_i   (mem_req_data_o),
    .mem_byteen_i (mem_req_byteen_o)
);

/* verification/dcache_tb.sv */
// ****************************************
// Directed testbench for the data cache
// Memory model answers after random delays
// Stops at the first mismatch or timeout
// ****************************************

`include "dcache_cfg.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT = 200;

    logic     clk;
    logic     reset;
    logic     core_req_valid_i;
    logic     core_req_ready_o;
    logic     core_req_rw_i;
    addr_u    core_req_addr_i;
    byteen_t  core_req_byteen_i;
    word_t    core_req_data_i;
    req_tag_t core_req_tag_i;
    logic     core_rsp_valid_o;
    logic     core_rsp_ready_i;
    word_t    core_rsp_data_o;
    req_tag_t core_rsp_tag_o;
    logic     mem_req_valid_o;
    logic     mem_req_ready_i;
    logic     mem_req_rw_o;
    addr_u    mem_req_addr_o;
    word_t    mem_req_data_o;
    byteen_t  mem_req_byteen_o;
    logic     mem_rsp_valid_i;
    line_t    mem_rsp_data_i;
    logic     mem_rsp_ready_o;

    logic [15:0] lfsr_state;

    // Backing store and the expected view of it
    word_t mem_words [0:65535];
    word_t exp_mem   [0:65535];

    // Observed memory requests and core responses
    logic     mem_log_rw   [$];
    addr_u    mem_log_addr [$];
    word_t    mem_log_data [$];
    byteen_t  mem_log_be   [$];
    word_t    rsp_data_log [$];
    req_tag_t rsp_tag_log  [$];

    dcache_top UUT (.*);

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int lfsr_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_bit());
        end
        return value;
    endfunction

    function automatic word_t fill_word(input logic [15:0] a);
        return {~a[7:0], a[15:8], a ^ 16'h3C5A};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input byteen_t be);
        word_t merged;
        merged = old;
        for (int b = 0; b < `DCACHE_BYTEEN_WIDTH; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_tag(input string what, input req_tag_t got, input req_tag_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input addr_u got, input addr_u exp);
        if (got.word_addr !== exp.word_addr) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got.word_addr, exp.word_addr));
        end
    endtask

    task automatic check_byteen(input string what, input byteen_t got, input byteen_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    // Random memory-side back-pressure
    always @(posedge clk) begin
        #1;
        mem_req_ready_i = lfsr_bit();
    end

    always @(posedge clk) begin
        if (!reset && core_rsp_valid_o && core_rsp_ready_i) begin
            rsp_data_log.push_back(core_rsp_data_o);
            rsp_tag_log.push_back(core_rsp_tag_o);
        end
    end

    // Memory model with at most one line read outstanding
    always begin : memory_model
        addr_u line_addr;
        line_t line;
        int    delay;
        int    cycles;
        logic  taken;
        @(posedge clk);
        if (!reset && mem_req_valid_o && mem_req_ready_i) begin
            mem_log_rw.push_back(mem_req_rw_o);
            mem_log_addr.push_back(mem_req_addr_o);
            mem_log_data.push_back(mem_req_data_o);
            mem_log_be.push_back(mem_req_byteen_o);
            if (mem_req_rw_o) begin
                mem_words[mem_req_addr_o.word_addr] =
                    merge_bytes(mem_words[mem_req_addr_o.word_addr], mem_req_data_o,
                                mem_req_byteen_o);
            end else begin
                line_addr = mem_req_addr_o;
                delay = lfsr_bits(3);
                repeat (delay) @(posedge clk);
                #1;
                for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                    line[w] = mem_words[line_addr.word_addr + 16'(w)];
                end
                mem_rsp_data_i  = line;
                mem_rsp_valid_i = 1'b1;
                cycles = 0;
                taken  = 1'b0;
                while (!taken) begin
                    @(posedge clk);
                    taken = mem_rsp_ready_o;
                    cycles++;
                    if (!taken && cycles > TIMEOUT) begin
                        stop_with_failure("Timeout: the cache never took the line from memory");
                    end
                end
                #1;
                mem_rsp_valid_i = 1'b0;
            end
        end
    end

    task automatic send_req(input logic rw, input addr_u addr, input byteen_t be,
                            input word_t data, input req_tag_t tag);
        int   cycles;
        logic accepted;
        core_req_valid_i  = 1'b1;
        core_req_rw_i     = rw;
        core_req_addr_i   = addr;
        core_req_byteen_i = be;
        core_req_data_i   = data;
        core_req_tag_i    = tag;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = core_req_ready_o;
            #1;
            cycles++;
            if (!accepted && cycles > TIMEOUT) begin
                stop_with_failure("Timeout: the cache did not accept a request");
            end
        end
        core_req_valid_i = 1'b0;
    endtask

    task automatic wait_responses(input int n);
        int cycles;
        cycles = 0;
        while (rsp_data_log.size() < n) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure("Timeout: a read response never arrived");
            end
        end
    endtask

    task automatic wait_mem_reqs(input int n);
        int cycles;
        cycles = 0;
        while (mem_log_rw.size() < n) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure("Timeout: an expected memory request never arrived");
            end
        end
    endtask

    task automatic wait_rsp_pending();
        int cycles;
        cycles = 0;
        while (!core_rsp_valid_o) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure("Timeout: no response was presented under back-pressure");
            end
        end
    endtask

    // Read one word and count the line reads it caused
    task automatic read_and_check(input logic [15:0] word_addr, input req_tag_t tag,
                                  input int line_reads);
        addr_u addr;
        addr_u line_addr;
        int    log_start;
        addr.word_addr = word_addr;
        log_start = mem_log_rw.size();
        send_req(1'b0, addr, '0, '0, tag);
        wait_responses(1);
        check_word("read data", rsp_data_log.pop_front(), exp_mem[word_addr]);
        check_tag("read tag", rsp_tag_log.pop_front(), tag);
        check_count("memory requests of a read", mem_log_rw.size() - log_start, line_reads);
        if (line_reads == 1) begin
            line_addr = addr;
            line_addr.fields.wsel = '0;
            check_flag("line read rw", mem_log_rw[log_start], 1'b0);
            check_addr("line read address", mem_log_addr[log_start], line_addr);
        end
    endtask

    task automatic write_and_check(input logic [15:0] word_addr, input byteen_t be,
                                   input word_t data);
        addr_u addr;
        int    log_start;
        addr.word_addr = word_addr;
        log_start = mem_log_rw.size();
        send_req(1'b1, addr, be, data, 4'hF);
        wait_mem_reqs(log_start + 1);
        check_flag("write rw", mem_log_rw[log_start], 1'b1);
        check_addr("write address", mem_log_addr[log_start], addr);
        check_word("write data", mem_log_data[log_start], data);
        check_byteen("write byte enables", mem_log_be[log_start], be);
        check_count("responses to a write", rsp_data_log.size(), 0);
        exp_mem[word_addr] = merge_bytes(exp_mem[word_addr], data, be);
    endtask

    task automatic read_miss_fill();
        read_and_check(16'h0126, 4'h1, 1);
    endtask

    task automatic read_hit_same_line();
        read_and_check(16'h0124, 4'h2, 0);
        read_and_check(16'h0125, 4'h3, 0);
        read_and_check(16'h0127, 4'h4, 0);
    endtask

    task automatic write_through();
        // Hit in the line filled above
        write_and_check(16'h0125, 4'b0101, 32'hA1B2_C3D4);
        read_and_check(16'h0125, 4'h5, 0);
        // Write miss allocates nothing so the read refetches
        write_and_check(16'h0A42, 4'b1100, 32'h5566_7788);
        read_and_check(16'h0A42, 4'h6, 1);
    endtask

    // Set 5 with tags 0x011, 0x022 and 0x033
    task automatic cyclic_replacement();
        read_and_check(16'h0455, 4'h7, 1);
        read_and_check(16'h0895, 4'h8, 1);
        read_and_check(16'h0CD5, 4'h9, 1);
        read_and_check(16'h0895, 4'hA, 0);
        read_and_check(16'h0455, 4'hB, 1);
    endtask

    task automatic backpressure_order();
        logic [15:0] addrs [3];
        req_tag_t    tags  [3];
        addr_u       addr;
        int          log_start;
        addrs = '{16'h3318, 16'h0127, 16'h7FF3};
        tags  = '{4'hC, 4'hD, 4'hE};
        log_start = mem_log_rw.size();
        core_rsp_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            addr.word_addr = addrs[i];
            send_req(1'b0, addr, '0, '0, tags[i]);
        end
        wait_rsp_pending();
        // Hold the stall so all three stages stay full
        repeat (3) @(posedge clk);
        #1;
        check_tag("stalled response tag", core_rsp_tag_o, tags[0]);
        check_word("stalled response data", core_rsp_data_o, exp_mem[addrs[0]]);
        check_flag("core request ready with three in flight", core_req_ready_o, 1'b0);
        core_rsp_ready_i = 1'b1;
        wait_responses(3);
        for (int i = 0; i < 3; i++) begin
            check_tag("tag in response order", rsp_tag_log.pop_front(), tags[i]);
            check_word("data in response order", rsp_data_log.pop_front(), exp_mem[addrs[i]]);
        end
        check_count("line reads under back-pressure", mem_log_rw.size() - log_start, 2);
    endtask

    initial begin
        clk               = 1'b0;
        reset             = 1'b1;
        core_req_valid_i  = 1'b0;
        core_req_rw_i     = 1'b0;
        core_req_addr_i   = '0;
        core_req_byteen_i = '0;
        core_req_data_i   = '0;
        core_req_tag_i    = '0;
        core_rsp_ready_i  = 1'b1;
        mem_req_ready_i   = 1'b0;
        mem_rsp_valid_i   = 1'b0;
        mem_rsp_data_i    = '0;
        lfsr_state        = 16'd24191;
        for (int a = 0; a < 65536; a++) begin
            mem_words[a] = fill_word(16'(a));
            exp_mem[a]   = fill_word(16'(a));
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        read_miss_fill();
        read_hit_same_line();
        write_through();
        cyclic_replacement();
        backpressure_order();

        $display("Test OK");
        $finish;
    end

endmodule

/* dcache_top.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_req_stage.sv
hdl/dcache_tag_stage.sv
hdl/dcache_data_stage.sv
hdl/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dcache_pkg.sv
      - hdl/dcache_req_stage.sv
      - hdl/dcache_tag_stage.sv
      - hdl/dcache_data_stage.sv
      - hdl/dcache_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/dcache_asserts.sv
      - verification/dcache_tb.sv
